/* src/snoop_pkg.sv */
`default_nettype none

package snoop_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int ADDR_W   = 44;
    localparam int DATA_W   = 128;
    // One 64 byte cache line in 16 byte beats
    localparam int BEATS    = 4;
    localparam int CRRESP_W = 5;

    // Any other code falls into the dummy reply
    typedef enum logic [3:0] {OSH = 4'd1, CON = 4'd2, PDT = 4'd5} func_e;

    typedef enum logic [3:0] {FUZZING = 4'd0, DELAY_CRVALID = 4'd1,
                              DELAY_CDVALID = 4'd2, DELAY_CDLAST = 4'd3} test_e;

    // ----------------------------------------------------------
    // Control word with enable in bit 0
    // ----------------------------------------------------------
    typedef struct packed {
        logic [12:0]         reserved;
        logic                pdt_en;
        logic                con_en;
        logic                osh_en;
        logic                addr_filter_en;
        logic                ac_filter_en;
        logic [CRRESP_W-1:0] crresp;
        logic [3:0]          func;
        test_e               test;
        logic                enable;
    } ctrl_t;

    typedef enum logic [1:0] {DUMMY, ONE_SHOT, CONTINUOUS, TAMPER} verdict_e;

    typedef enum logic [3:0] {IDLE, DECODE_WAIT, DELAY_WAIT_READY, DATA_REPLY,
                              DUMMY_REPLY, RESPOND, DELAY, END_OP,
                              END_REPLY} exec_state_e;

    // Next value of the CR/CD channel registers
    typedef struct packed {
        logic                crvalid;
        logic                cdvalid;
        logic                cdlast;
        logic [CRRESP_W-1:0] crresp;
        logic [1:0]          beat;
        logic                clear_data;
    } reply_cmd_t;

endpackage

`default_nettype wire

/* src/snoop_filter_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module snoop_filter_decode #(
    parameter int ADDR_W = snoop_pkg::ADDR_W
) (
    input  wire                        ace_aclk,
    input  wire                        ace_aresetn,
    input  wire                        i_trigger,
    input  wire [ADDR_W-1:0]           i_acaddr_snapshot,
    input  wire [3:0]                  i_acsnoop_snapshot,
    input  wire snoop_pkg::ctrl_t      i_control,
    input  wire [3:0]                  i_acsnoop_reg,
    input  wire [31:0]                 i_base_addr_reg,
    input  wire [31:0]                 i_addr_size_reg,
    input  wire                        i_oneshot_done,
    output snoop_pkg::verdict_e        o_verdict,
    output logic                       o_verdict_valid
);

    logic [31:0]         snoop_addr;
    logic [31:0]         window_end;
    logic                opcode_hit;
    logic                addr_hit;
    logic                filter_pass;
    snoop_pkg::verdict_e verdict_next;

    // ----------------------------------------------------------
    // Filters
    // ----------------------------------------------------------
    // Window compare uses only the low 32 address bits
    assign snoop_addr = i_acaddr_snapshot[31:0];
    assign window_end = i_base_addr_reg + i_addr_size_reg;
    assign opcode_hit = (i_acsnoop_snapshot == i_acsnoop_reg);
    assign addr_hit   = (snoop_addr >= i_base_addr_reg) && (snoop_addr < window_end);

    // A disabled filter lets every snoop through
    assign filter_pass = (!i_control.ac_filter_en || opcode_hit) &&
                         (!i_control.addr_filter_en || addr_hit);

    // ----------------------------------------------------------
    // Function selection
    // ----------------------------------------------------------
    always_comb
    begin
        verdict_next = snoop_pkg::DUMMY;
        if (i_control.enable && filter_pass)
        begin
            // Used one-shot degrades to a dummy reply
            if ((i_control.func == snoop_pkg::OSH) && i_control.osh_en && !i_oneshot_done)
                verdict_next = snoop_pkg::ONE_SHOT;
            else if ((i_control.func == snoop_pkg::CON) && i_control.con_en)
                verdict_next = snoop_pkg::CONTINUOUS;
            else if ((i_control.func == snoop_pkg::PDT) && i_control.pdt_en)
                verdict_next = snoop_pkg::TAMPER;
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            o_verdict_valid <= 1'b0;
        else
            o_verdict_valid <= i_trigger;
    end

    always_ff @(posedge ace_aclk)
    begin
        if (i_trigger)
            o_verdict <= verdict_next;
    end

endmodule

`default_nettype wire

/* src/reply_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module reply_sequencer #(
    parameter int DELAY_UNIT = 4
) (
    input  wire                        ace_aclk,
    input  wire                        ace_aresetn,
    input  wire                        i_trigger,
    input  wire snoop_pkg::verdict_e   i_verdict,
    input  wire                        i_verdict_valid,
    input  wire snoop_pkg::ctrl_t      i_control,
    input  wire [31:0]                 i_delay_reg,
    input  wire                        i_crready,
    input  wire                        i_cdready,
    output snoop_pkg::reply_cmd_t      o_cmd,
    output logic                       o_busy,
    output logic                       o_reply,
    output logic                       o_end,
    output logic                       o_oneshot_done
);

    localparam logic [1:0] LAST_BEAT = 2'(snoop_pkg::BEATS - 1);

    snoop_pkg::exec_state_e r_state;
    snoop_pkg::verdict_e    r_verdict;
    logic                   r_last;
    logic [1:0]             r_beat;
    logic [31:0]            r_count;
    logic [31:0]            delay_target;
    logic                   delay_done;
    logic                   delay_mode;
    logic                   final_beat;
    logic [1:0]             next_beat;
    logic [1:0]             data_beat;
    logic                   burst_on;
    logic                   strobe_phase;
    snoop_pkg::exec_state_e end_state;

    // ----------------------------------------------------------
    // Delay and beat bookkeeping
    // ----------------------------------------------------------
    assign delay_target = (i_delay_reg == 32'd0) ? 32'd0 :
                          (32'(DELAY_UNIT) << (i_delay_reg - 32'd1));
    assign delay_done   = (r_count == delay_target);
    assign delay_mode   = (i_control.test == snoop_pkg::DELAY_CRVALID) ||
                          (i_control.test == snoop_pkg::DELAY_CDVALID) ||
                          (i_control.test == snoop_pkg::DELAY_CDLAST);

    assign final_beat = (r_beat == LAST_BEAT);
    assign next_beat  = r_beat + 2'd1;
    // Beat advances in the cycle the current one is taken
    assign data_beat  = ((r_state == snoop_pkg::DATA_REPLY) && i_cdready) ? next_beat : r_beat;

    assign burst_on = ((r_state == snoop_pkg::DELAY_WAIT_READY) &&
                       (r_verdict == snoop_pkg::TAMPER) && i_crready) ||
                      ((r_state == snoop_pkg::DATA_REPLY) && !(i_cdready && final_beat));

    assign strobe_phase = (r_state == snoop_pkg::RESPOND) || (r_state == snoop_pkg::DELAY);
    assign end_state    = r_last ? snoop_pkg::END_OP : snoop_pkg::END_REPLY;
    assign o_busy       = (r_state != snoop_pkg::IDLE);

    // ----------------------------------------------------------
    // Command to the result stage
    // ----------------------------------------------------------
    always_comb
    begin
        o_cmd      = '0;
        o_cmd.beat = data_beat;
        if (burst_on)
        begin
            o_cmd.crvalid = 1'b1;
            o_cmd.cdvalid = 1'b1;
            o_cmd.cdlast  = (data_beat == LAST_BEAT);
            o_cmd.crresp  = i_control.crresp;
        end
        else if (strobe_phase)
        begin
            // Named strobe held back until the count runs out
            o_cmd.crvalid = (i_control.test != snoop_pkg::DELAY_CRVALID) ||
                            ((r_state == snoop_pkg::DELAY) && delay_done);
            o_cmd.cdvalid = (i_control.test != snoop_pkg::DELAY_CDVALID) ||
                            ((r_state == snoop_pkg::DELAY) && delay_done);
            o_cmd.cdlast  = (i_control.test != snoop_pkg::DELAY_CDLAST) ||
                            ((r_state == snoop_pkg::DELAY) && delay_done);
            o_cmd.crresp  = i_control.crresp;
        end
        else if (r_state == snoop_pkg::DUMMY_REPLY)
        begin
            o_cmd.crvalid    = i_crready;
            o_cmd.clear_data = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_state        <= snoop_pkg::IDLE;
            r_verdict      <= snoop_pkg::DUMMY;
            r_last         <= 1'b0;
            r_beat         <= 2'd0;
            r_count        <= 32'd0;
            o_reply        <= 1'b0;
            o_end          <= 1'b0;
            o_oneshot_done <= 1'b0;
        end
        else
        begin
            o_reply <= 1'b0;
            unique case (r_state)
                snoop_pkg::IDLE:
                begin
                    // End and one-shot flags live for one enable period
                    if (!i_control.enable)
                    begin
                        o_end          <= 1'b0;
                        o_oneshot_done <= 1'b0;
                    end
                    if (i_trigger)
                        r_state <= snoop_pkg::DECODE_WAIT;
                end
                snoop_pkg::DECODE_WAIT:
                begin
                    if (i_verdict_valid)
                    begin
                        r_verdict <= i_verdict;
                        if (i_verdict == snoop_pkg::DUMMY)
                            r_state <= snoop_pkg::DUMMY_REPLY;
                        else
                            r_state <= snoop_pkg::DELAY_WAIT_READY;
                    end
                end
                snoop_pkg::DELAY_WAIT_READY:
                begin
                    if (i_crready && (r_verdict == snoop_pkg::TAMPER))
                        r_state <= snoop_pkg::DATA_REPLY;
                    else if (i_crready)
                    begin
                        // Continuous run ends once con_en drops
                        r_last  <= (r_verdict == snoop_pkg::ONE_SHOT) || !i_control.con_en;
                        r_state <= snoop_pkg::RESPOND;
                    end
                end
                snoop_pkg::DATA_REPLY:
                begin
                    if (i_cdready && final_beat)
                        r_state <= snoop_pkg::END_REPLY;
                    else if (i_cdready)
                        r_beat <= next_beat;
                end
                snoop_pkg::DUMMY_REPLY:
                begin
                    if (i_crready)
                        r_state <= snoop_pkg::END_REPLY;
                end
                snoop_pkg::RESPOND:
                begin
                    if (r_verdict == snoop_pkg::ONE_SHOT)
                        o_oneshot_done <= 1'b1;
                    r_state <= delay_mode ? snoop_pkg::DELAY : end_state;
                end
                snoop_pkg::DELAY:
                begin
                    if (delay_done)
                    begin
                        r_count <= 32'd0;
                        r_state <= end_state;
                    end
                    else
                        r_count <= r_count + 32'd1;
                end
                snoop_pkg::END_OP:
                begin
                    o_end   <= 1'b1;
                    o_reply <= 1'b1;
                    r_beat  <= 2'd0;
                    r_state <= snoop_pkg::IDLE;
                end
                snoop_pkg::END_REPLY:
                begin
                    o_reply <= 1'b1;
                    r_beat  <= 2'd0;
                    r_state <= snoop_pkg::IDLE;
                end
                default:
                    r_state <= snoop_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/snoop_reply_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module snoop_reply_driver (
    input  wire                                             ace_aclk,
    input  wire                                             ace_aresetn,
    input  wire snoop_pkg::reply_cmd_t                      i_cmd,
    input  wire [snoop_pkg::BEATS*snoop_pkg::DATA_W-1:0]    i_cache_line,
    output logic                                            o_crvalid,
    output logic [snoop_pkg::CRRESP_W-1:0]                  o_crresp,
    output logic                                            o_cdvalid,
    output logic [snoop_pkg::DATA_W-1:0]                    o_cddata,
    output logic                                            o_cdlast
);

    logic [snoop_pkg::DATA_W-1:0] beat_data;

    // Beat 0 sits in the low bits of the line
    always_comb
    begin
        beat_data = i_cache_line[i_cmd.beat*snoop_pkg::DATA_W +: snoop_pkg::DATA_W];
    end

    // ----------------------------------------------------------
    // CR and CD channel registers
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_crvalid <= 1'b0;
            o_crresp  <= '0;
            o_cdvalid <= 1'b0;
            o_cdlast  <= 1'b0;
        end
        else
        begin
            o_crvalid <= i_cmd.crvalid;
            o_crresp  <= i_cmd.crresp;
            o_cdvalid <= i_cmd.cdvalid;
            o_cdlast  <= i_cmd.cdlast;
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            o_cddata <= '0;
        else if (i_cmd.clear_data)
            o_cddata <= '0;
        else if (i_cmd.cdvalid)
            o_cddata <= beat_data;
    end

endmodule

`default_nettype wire

/* src/passive_snoop_responder.sv */
`timescale 1ns/10ps
`default_nettype none

module passive_snoop_responder #(
    parameter int ADDR_W     = snoop_pkg::ADDR_W,
    parameter int DELAY_UNIT = 4
) (
    input  wire                                             ace_aclk,
    input  wire                                             ace_aresetn,
    // Captured snoop
    input  wire                                             i_trigger,
    input  wire [ADDR_W-1:0]                                i_acaddr_snapshot,
    input  wire [3:0]                                       i_acsnoop_snapshot,
    // Configuration
    input  wire snoop_pkg::ctrl_t                           i_control,
    input  wire [31:0]                                      i_delay_reg,
    input  wire [3:0]                                       i_acsnoop_reg,
    input  wire [31:0]                                      i_base_addr_reg,
    input  wire [31:0]                                      i_addr_size_reg,
    input  wire [snoop_pkg::BEATS*snoop_pkg::DATA_W-1:0]    i_cache_line,
    // CR and CD channels
    input  wire                                             i_crready,
    input  wire                                             i_cdready,
    output wire                                             o_crvalid,
    output wire [snoop_pkg::CRRESP_W-1:0]                   o_crresp,
    output wire                                             o_cdvalid,
    output wire [snoop_pkg::DATA_W-1:0]                     o_cddata,
    output wire                                             o_cdlast,
    // Status
    output wire                                             o_busy,
    output wire                                             o_reply,
    output wire                                             o_end,
    output wire                                             o_oneshot_done
);

    wire snoop_pkg::verdict_e   verdict;
    wire                        verdict_valid;
    wire snoop_pkg::reply_cmd_t reply_cmd;

    snoop_filter_decode #(
        .ADDR_W             (ADDR_W)
    ) i_snoop_filter_decode (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_trigger          (i_trigger),
        .i_acaddr_snapshot  (i_acaddr_snapshot),
        .i_acsnoop_snapshot (i_acsnoop_snapshot),
        .i_control          (i_control),
        .i_acsnoop_reg      (i_acsnoop_reg),
        .i_base_addr_reg    (i_base_addr_reg),
        .i_addr_size_reg    (i_addr_size_reg),
        .i_oneshot_done     (o_oneshot_done),
        .o_verdict          (verdict),
        .o_verdict_valid    (verdict_valid)
    );

    reply_sequencer #(
        .DELAY_UNIT         (DELAY_UNIT)
    ) i_reply_sequencer (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_trigger          (i_trigger),
        .i_verdict          (verdict),
        .i_verdict_valid    (verdict_valid),
        .i_control          (i_control),
        .i_delay_reg        (i_delay_reg),
        .i_crready          (i_crready),
        .i_cdready          (i_cdready),
        .o_cmd              (reply_cmd),
        .o_busy             (o_busy),
        .o_reply            (o_reply),
        .o_end              (o_end),
        .o_oneshot_done     (o_oneshot_done)
    );

    snoop_reply_driver i_snoop_reply_driver (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_cmd              (reply_cmd),
        .i_cache_line       (i_cache_line),
        .o_crvalid          (o_crvalid),
        .o_crresp           (o_crresp),
        .o_cdvalid          (o_cdvalid),
        .o_cddata           (o_cddata),
        .o_cdlast           (o_cdlast)
    );

endmodule

`default_nettype wire

/* bench/tb_passive_snoop.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_passive_snoop;

    localparam int          CLK_PERIOD        = 8;
    localparam int          DRIVE_DELAY       = 1;
    localparam int          DELAY_UNIT        = 4;
    localparam int          MAX_RECORDS       = 64;
    localparam int          CYCLES_PER_RECORD = 2000;
    localparam int          LINE_W            = snoop_pkg::BEATS * snoop_pkg::DATA_W;
    localparam logic [31:0] LFSR_SEED         = 32'he677;
    // Reply kinds as coded in the trace
    localparam int KIND_DUMMY      = 0;
    localparam int KIND_ONE_SHOT   = 1;
    localparam int KIND_CONTINUOUS = 2;
    localparam int KIND_TAMPER     = 3;

    logic                                ace_aclk;
    logic                                ace_aresetn;
    logic                                trigger;
    logic [snoop_pkg::ADDR_W-1:0]        acaddr;
    logic [3:0]                          acsnoop;
    snoop_pkg::ctrl_t                    ctrl;
    logic [31:0]                         delay_reg;
    logic [3:0]                          acsnoop_reg;
    logic [31:0]                         base_reg;
    logic [31:0]                         size_reg;
    logic [LINE_W-1:0]                   cache_line;
    logic                                crready;
    logic                                cdready;
    wire                                 crvalid;
    wire  [snoop_pkg::CRRESP_W-1:0]      crresp;
    wire                                 cdvalid;
    wire  [snoop_pkg::DATA_W-1:0]        cddata;
    wire                                 cdlast;
    wire                                 busy;
    wire                                 reply;
    wire                                 end_level;
    wire                                 oneshot_level;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic        trace_loaded = 1'b0;
    int          trace_count = 0;
    logic        model_end = 1'b0;
    logic        model_oneshot = 1'b0;

    // Trace columns
    logic [31:0] rec_ctrl   [MAX_RECORDS];
    logic [31:0] rec_snoop  [MAX_RECORDS];
    logic [63:0] rec_addr   [MAX_RECORDS];
    logic [31:0] rec_opcode [MAX_RECORDS];
    logic [31:0] rec_base   [MAX_RECORDS];
    logic [31:0] rec_size   [MAX_RECORDS];
    logic [31:0] rec_delay  [MAX_RECORDS];
    logic [31:0] rec_clear  [MAX_RECORDS];
    logic [31:0] rec_kind   [MAX_RECORDS];

    passive_snoop_responder #(
        .ADDR_W             (snoop_pkg::ADDR_W),
        .DELAY_UNIT         (DELAY_UNIT)
    ) i_passive_snoop_responder (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_trigger          (trigger),
        .i_acaddr_snapshot  (acaddr),
        .i_acsnoop_snapshot (acsnoop),
        .i_control          (ctrl),
        .i_delay_reg        (delay_reg),
        .i_acsnoop_reg      (acsnoop_reg),
        .i_base_addr_reg    (base_reg),
        .i_addr_size_reg    (size_reg),
        .i_cache_line       (cache_line),
        .i_crready          (crready),
        .i_cdready          (cdready),
        .o_crvalid          (crvalid),
        .o_crresp           (crresp),
        .o_cdvalid          (cdvalid),
        .o_cddata           (cddata),
        .o_cdlast           (cdlast),
        .o_busy             (busy),
        .o_reply            (reply),
        .o_end              (end_level),
        .o_oneshot_done     (oneshot_level)
    );

    initial
    begin
        ace_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) ace_aclk = ~ace_aclk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    task automatic fail_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s (got %0h, expected %0h)", $time, what, actual,
                     expected);
            fail_run();
        end
    endtask

    task automatic drive_readies();
        crready = lfsr_bit();
        cdready = lfsr_bit();
    endtask

    task automatic next_cycle();
        @(posedge ace_aclk);
        #DRIVE_DELAY;
        trigger = 1'b0;
        drive_readies();
        @(negedge ace_aclk);
    endtask

    // Verdict rule recomputed from the filter and function fields
    function automatic int reference_kind(input snoop_pkg::ctrl_t c, input logic [3:0] snoop,
                                          input logic [3:0] opcode, input logic [31:0] addr,
                                          input logic [31:0] base, input logic [31:0] size,
                                          input logic used);
        logic [32:0] window_hi;
        logic        opcode_ok;
        logic        addr_ok;
        window_hi = {1'b0, base} + {1'b0, size};
        opcode_ok = !c.ac_filter_en || (snoop == opcode);
        addr_ok   = !c.addr_filter_en ||
                    (({1'b0, addr} >= {1'b0, base}) && ({1'b0, addr} < window_hi));
        if (!c.enable || !opcode_ok || !addr_ok)
            return KIND_DUMMY;
        if ((c.func == snoop_pkg::OSH) && c.osh_en && !used)
            return KIND_ONE_SHOT;
        if ((c.func == snoop_pkg::CON) && c.con_en)
            return KIND_CONTINUOUS;
        if ((c.func == snoop_pkg::PDT) && c.pdt_en)
            return KIND_TAMPER;
        return KIND_DUMMY;
    endfunction

    task automatic load_trace();
        int    fd;
        int    fields;
        string line_text;
        fd = $fopen("bench/snoop_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file bench/snoop_trace.txt");
            fail_run();
        end
        while (!$feof(fd) && (trace_count < MAX_RECORDS))
        begin
            line_text = "";
            void'($fgets(line_text, fd));
            if ((line_text.len() > 0) && (line_text[0] != "#"))
            begin
                fields = $sscanf(line_text, "%h %h %h %h %h %h %h %h %h",
                                 rec_ctrl[trace_count], rec_snoop[trace_count],
                                 rec_addr[trace_count], rec_opcode[trace_count],
                                 rec_base[trace_count], rec_size[trace_count],
                                 rec_delay[trace_count], rec_clear[trace_count],
                                 rec_kind[trace_count]);
                if (fields == 9)
                    trace_count++;
                else if (fields > 0)
                begin
                    $display("Malformed trace line: %s", line_text);
                    fail_run();
                end
            end
        end
        $fclose(fd);
        trace_loaded = 1'b1;
    endtask

    // ----------------------------------------------------------
    // One trace record from snoop to reply
    // ----------------------------------------------------------
    task automatic run_record(input int idx);
        snoop_pkg::ctrl_t               c;
        logic [snoop_pkg::CRRESP_W-1:0] resp;
        int kind;
        int cycle;
        int cr_rise;
        int cd_rise;
        int last_rise;
        int beats;
        int need;
        int named;
        int early_a;
        int early_b;
        c         = snoop_pkg::ctrl_t'(rec_ctrl[idx]);
        cr_rise   = -1;
        cd_rise   = -1;
        last_rise = -1;
        beats     = 0;
        // Enable low ends the one-shot period
        if ((rec_clear[idx] != 0) || !c.enable)
        begin
            @(posedge ace_aclk);
            #DRIVE_DELAY;
            ctrl = '0;
            @(negedge ace_aclk);
            next_cycle();
            next_cycle();
            model_end     = 1'b0;
            model_oneshot = 1'b0;
            check_equal(128'({end_level, oneshot_level}), 128'(0), "flags clear with enable");
        end
        kind = reference_kind(c, rec_snoop[idx][3:0], rec_opcode[idx][3:0],
                              rec_addr[idx][31:0], rec_base[idx], rec_size[idx], model_oneshot);
        check_equal(128'(kind), 128'(rec_kind[idx]), "trace kind against reference");
        resp = (kind == KIND_DUMMY) ? '0 : c.crresp;

        @(posedge ace_aclk);
        #DRIVE_DELAY;
        ctrl        = c;
        acsnoop     = rec_snoop[idx][3:0];
        acaddr      = rec_addr[idx][snoop_pkg::ADDR_W-1:0];
        acsnoop_reg = rec_opcode[idx][3:0];
        base_reg    = rec_base[idx];
        size_reg    = rec_size[idx];
        delay_reg   = rec_delay[idx];
        for (int b = 0; b < LINE_W; b++)
            cache_line[b] = lfsr_bit();
        trigger = 1'b1;
        drive_readies();
        next_cycle();

        cycle = 0;
        while (!reply)
        begin
            check_equal(128'(busy), 128'(1), "busy during reply");
            if (crvalid)
                check_equal(128'(crresp), 128'(resp), "CR response");
            // Dummy reply carries cleared data
            if ((kind == KIND_DUMMY) && crvalid)
                check_equal(cddata, 128'(0), "dummy reply data");
            if (crvalid && (cr_rise < 0))
                cr_rise = cycle;
            if (cdvalid && (cd_rise < 0))
                cd_rise = cycle;
            if (cdlast && (last_rise < 0))
                last_rise = cycle;
            // A beat is taken where cdvalid meets cdready
            if ((kind == KIND_TAMPER) && cdvalid && cdready)
            begin
                check_equal(cddata, cache_line[beats * snoop_pkg::DATA_W +: snoop_pkg::DATA_W],
                            "tamper beat data");
                check_equal(128'(cdlast), 128'(beats == snoop_pkg::BEATS - 1), "cdlast");
                beats++;
            end
            next_cycle();
            cycle++;
        end

        if (kind == KIND_ONE_SHOT)
        begin
            model_end     = 1'b1;
            model_oneshot = 1'b1;
        end
        check_equal(128'({busy, crvalid, cdvalid, cdlast}), 128'(0), "idle after reply");
        check_equal(128'(end_level), 128'(model_end), "end flag");
        check_equal(128'(oneshot_level), 128'(model_oneshot), "one-shot flag");
        check_equal(128'(cr_rise >= 0), 128'(1), "crvalid raised");

        if (kind == KIND_DUMMY)
            check_equal(128'(cd_rise < 0), 128'(1), "no data on dummy reply");
        else if (kind == KIND_TAMPER)
            check_equal(128'(beats), 128'(snoop_pkg::BEATS), "tamper beat count");
        else
        begin
            need = (rec_delay[idx] == 0) ? 0 : DELAY_UNIT << (int'(rec_delay[idx]) - 1);
            if (need < 1)
                need = 1;
            named   = cr_rise;
            early_a = cd_rise;
            early_b = last_rise;
            if (c.test == snoop_pkg::DELAY_CDVALID)
            begin
                named   = cd_rise;
                early_a = cr_rise;
            end
            else if (c.test == snoop_pkg::DELAY_CDLAST)
            begin
                named   = last_rise;
                early_b = cr_rise;
            end
            check_equal(128'(early_a >= 0), 128'(1), "early strobes raised");
            check_equal(128'(early_a), 128'(early_b), "early strobes together");
            if (c.test == snoop_pkg::FUZZING)
                check_equal(128'(named), 128'(early_a), "fuzzing strobes together");
            else
                check_equal(128'(named - early_a >= need), 128'(1), "named strobe delay");
        end
        next_cycle();
        check_equal(128'(reply), 128'(0), "reply is one cycle");
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------
    initial
    begin
        ace_aresetn = 1'b0;
        trigger     = 1'b0;
        acaddr      = '0;
        acsnoop     = '0;
        ctrl        = '0;
        delay_reg   = '0;
        acsnoop_reg = '0;
        base_reg    = '0;
        size_reg    = '0;
        cache_line  = '0;
        crready     = 1'b0;
        cdready     = 1'b0;
        load_trace();
        repeat (8) @(posedge ace_aclk);
        #DRIVE_DELAY;
        ace_aresetn = 1'b1;
        @(negedge ace_aclk);
        check_equal(128'({crvalid, cdvalid, cdlast, busy, reply, end_level, oneshot_level}),
                    128'(0), "outputs after reset");
        check_equal(128'(crresp), 128'(0), "CR response after reset");
        check_equal(cddata, 128'(0), "CD data after reset");
        for (int r = 0; r < trace_count; r++)
            run_record(r);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin
        wait (trace_loaded);
        repeat (trace_count * CYCLES_PER_RECORD + 100) @(posedge ace_aclk);
        $display("Timeout: the trace did not finish within its cycle budget");
        fail_run();
    end

endmodule

`default_nettype wire

/* bench/snoop_trace.txt */
# control snoop address opcode_reg base size delay clear kind, all in hex
# clear 1 drops enable first; kind 0 dummy, 1 one-shot, 2 continuous, 3 tamper
000446A1 7 00000001000 1 00000000 00000000 0 1 0
000486A1 0 00000001000 0 00001000 00000040 0 1 3
000486A1 0 00000001040 0 00001000 00000040 0 1 0
000486A1 0 00000000FFF 0 00001000 00000040 0 1 0
00043EA1 3 00000004000 0 00000000 00000000 0 1 3
0004FEA1 9 ABC20000010 9 20000000 00000100 0 1 3
00010A23 1 00000000100 0 00000000 00000000 2 1 1
00010A23 1 00000000100 0 00000000 00000000 2 0 0
00010A23 1 00000000100 0 00000000 00000000 0 1 1
00000A23 1 00000000100 0 00000000 00000000 0 1 0
00020245 2 00000000200 0 00000000 00000000 1 1 2
00020247 2 00000000200 0 00000000 00000000 3 0 2
00020241 2 00000000200 0 00000000 00000000 5 0 2
00010A21 1 00000000100 0 00000000 00000000 0 1 1
00043EA0 3 00000004000 0 00000000 00000000 0 1 0
00070661 3 00000004000 0 00000000 00000000 0 0 0
00028245 2 00000005000 0 00001000 00000100 1 1 0
00043EA1 5 0000000C0C0 0 00000000 00000000 0 0 3

/* sources.f */
src/snoop_pkg.sv
src/snoop_filter_decode.sv
src/reply_sequencer.sv
src/snoop_reply_driver.sv
src/passive_snoop_responder.sv
bench/tb_passive_snoop.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_passive_snoop
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
